// ==== all.f ====
pcie_mmio_pkg.sv
pcie_reset_seq.sv
tlp_rx_decoder.sv
mmio_regfile.sv
tlp_cpl_builder.sv
pcie_mmio_top.sv
pcie_mmio_properties.sv
tb_pcie_mmio.sv

// ==== Bender.yml ====
package:
  name: pcie_mmio

sources:
  - pcie_mmio_pkg.sv
  - pcie_reset_seq.sv
  - tlp_rx_decoder.sv
  - mmio_regfile.sv
  - tlp_cpl_builder.sv
  - pcie_mmio_top.sv
  - target: test
    files:
      - pcie_mmio_properties.sv
      - tb_pcie_mmio.sv

// ==== tb_pcie_mmio.sv ====
/* pcie mmio endpoint testbench */
`timescale 1ns/1ns

module tb_pcie_mmio;
  import pcie_mmio_pkg::*;

  localparam logic [31:0] EXP_ID  = 32'h9999_10ee;
  localparam int          TIMEOUT = 200;

  logic          user_clk = 1'b0;
  logic          NO_RESET;
  logic          link_up;
  completer_id_t cfg_completer_id;
  axis_beat_t    rx_beat;
  logic          rx_valid;
  logic          rx_ready;
  axis_beat_t    tx_beat;
  logic          tx_valid;
  logic          tx_ready;
  logic [3:0]    led;

  logic [31:0]   model [16];
  axis_beat_t    cpl_q [$];
  logic          ready_pat [256];
  logic          bp_on = 1'b0;
  int            cyc = 0;
  int            checks = 0;
  int            errors = 0;
  int            reads_sent = 0;
  int            cpl_seen = 0;

  pcie_mmio_top #(.RESET_HOLD(16)) i_dut (.*);

  always #5 user_clk = ~user_clk;

  // tx back-pressure replayed from a random table
  always @(posedge user_clk) begin
    #1;
    tx_ready = !bp_on || ready_pat[cyc];
    cyc = (cyc + 1) % 256;
  end

  // collect every accepted completion beat
  always @(negedge user_clk) begin
    if (tx_valid === 1'b1 && tx_ready === 1'b1) begin
      cpl_q.push_back(tx_beat);
      if (tx_beat.last) cpl_seen++;
    end
  end

  function automatic logic [1:0] first_offset(input logic [3:0] be);
    first_offset = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (be[i]) first_offset = 2'(i);
    end
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    finish_run();
  endtask

  // present one beat and hold it until the decoder takes it
  task automatic send_beat(input axis_beat_t b);
    int n;
    n = 0;
    rx_beat  = b;
    rx_valid = 1'b1;
    @(negedge user_clk);
    while (rx_ready !== 1'b1) begin
      n++;
      if (n > TIMEOUT) give_up("rx_ready");
      @(negedge user_clk);
    end
    @(posedge user_clk);
    #1;
  endtask

  task automatic wait_cpl();
    int n;
    n = 0;
    while (cpl_q.size() < 2) begin
      n++;
      if (n > TIMEOUT) give_up("a completion on tx");
      @(posedge user_clk);
      #1;
    end
  endtask

  task automatic write_reg(input int idx, input logic [3:0] be);
    logic [31:0] wdata;
    logic [31:0] addr;
    wdata = $urandom;
    addr  = ($urandom & 32'hffff_ffc0) | 32'(idx << 2);
    send_beat('{data: {16'($urandom), 8'($urandom), 4'h0, be, FMT_TYPE_MWR32, 14'd0, 10'd1},
                keep: 2'b11, last: 1'b0});
    send_beat('{data: {wdata, addr}, keep: 2'b11, last: 1'b1});
    rx_valid = 1'b0;
    // identity word has no storage
    if (idx != 0) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic read_and_check(input int idx, input logic [3:0] be);
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [31:0] addr;
    logic [31:0] exp_data;
    axis_beat_t  c0;
    axis_beat_t  c1;
    req_id   = 16'($urandom);
    tag      = 8'($urandom);
    addr     = ($urandom & 32'hffff_ffc0) | 32'(idx << 2);
    exp_data = (idx == 0) ? EXP_ID : model[idx];
    check_val("cpl_q.size", cpl_q.size(), 0);
    send_beat('{data: {req_id, tag, 4'h0, be, FMT_TYPE_MRD32, 14'd0, 10'd1},
                keep: 2'b11, last: 1'b0});
    send_beat('{data: {32'h0, addr}, keep: 2'b01, last: 1'b1});
    rx_valid = 1'b0;
    reads_sent++;
    wait_cpl();
    c0 = cpl_q.pop_front();
    c1 = cpl_q.pop_front();
    // cpld, length 1, successful, byte count 4
    check_val("tx_beat0.data", c0.data,
              {cfg_completer_id, 3'b000, 1'b0, 12'd4, 8'h4a, 14'd0, 10'd1});
    check_val("tx_beat0.keep", c0.keep, 2'b11);
    check_val("tx_beat0.last", c0.last, 1'b0);
    check_val("tx_beat1.data", c1.data,
              {exp_data, req_id, tag, 1'b0, addr[6:2], first_offset(be)});
    check_val("tx_beat1.keep", c1.keep, 2'b11);
    check_val("tx_beat1.last", c1.last, 1'b1);
  endtask

  // packets the endpoint must swallow without a reply
  task automatic inject_junk(input int idx);
    logic [7:0]  codes [5] = '{8'h20, 8'h60, 8'h04, 8'h44, 8'h0a};
    logic [7:0]  code;
    logic [9:0]  len;
    logic [63:0] data;
    int          nbeats;
    if ($urandom_range(0, 1) == 1) begin
      code = codes[$urandom_range(0, 4)];
      len  = 10'd1;
    end else begin
      code = ($urandom_range(0, 1) == 1) ? FMT_TYPE_MWR32 : FMT_TYPE_MRD32;
      len  = 10'($urandom_range(2, 8));
    end
    nbeats = $urandom_range(1, 3);
    for (int i = 0; i < nbeats; i++) begin
      if (i == 0) begin
        data = {16'($urandom), 8'($urandom), 4'h0, 4'hf, code, 14'd0, len};
      end else begin
        data = {32'($urandom), ($urandom & 32'hffff_ffc0) | 32'(idx << 2)};
      end
      send_beat('{data: data, keep: 2'b11, last: (i == nbeats - 1)});
    end
    rx_valid = 1'b0;
  endtask

  initial begin
    int n;
    int idx;
    int q_idx [$];
    void'($urandom(32'h82c9_dad3));
    NO_RESET         = 1'b1;
    link_up          = 1'b0;
    rx_valid         = 1'b0;
    rx_beat          = '0;
    tx_ready         = 1'b0;
    cfg_completer_id = 16'($urandom);
    for (int i = 0; i < 16; i++) model[i] = '0;
    for (int i = 0; i < 256; i++) ready_pat[i] = 1'($urandom_range(0, 1));
    repeat (5) @(posedge user_clk);
    #1;
    NO_RESET = 1'b0;

    // core still held, link down
    @(negedge user_clk);
    check_val("led", led, 4'b1101);
    n = 1;
    while (led[1] !== 1'b1) begin
      n++;
      if (n > TIMEOUT) give_up("core reset release");
      @(negedge user_clk);
    end
    checks++;
    assert (n >= 16) else begin
      errors++;
      $display("core reset released after only %0d cycles", n);
    end
    check_val("tx_valid", tx_valid, 1'b0);
    check_val("rx_ready", rx_ready, 1'b1);
    check_val("led", led, 4'b1111);

    // link status shows up one register later
    @(posedge user_clk);
    #1;
    link_up = 1'b1;
    @(negedge user_clk);
    check_val("led[0]", led[0], 1'b1);
    @(negedge user_clk);
    check_val("led[0]", led[0], 1'b0);
    @(posedge user_clk);
    #1;

    for (int i = 0; i < 16; i++) read_and_check(i, 4'hf);

    write_reg(0, 4'hf);
    read_and_check(0, 4'hf);
    repeat (24) begin
      idx = $urandom_range(0, 15);
      q_idx.push_back(idx);
      write_reg(idx, 4'($urandom));
    end
    foreach (q_idx[i]) read_and_check(q_idx[i], 4'($urandom_range(1, 15)));

    // mixed traffic under random back-pressure
    bp_on = 1'b1;
    repeat (80) begin
      idx = $urandom_range(0, 15);
      case ($urandom_range(0, 2))
        0: write_reg(idx, 4'($urandom));
        1: read_and_check(idx, 4'($urandom_range(1, 15)));
        default: inject_junk(idx);
      endcase
    end
    for (int i = 0; i < 16; i++) read_and_check(i, 4'hf);

    repeat (20) @(posedge user_clk);
    check_val("cpl_q.size", cpl_q.size(), 0);
    check_val("completions", cpl_seen, reads_sent);
    finish_run();
  end

endmodule

// ==== pcie_mmio_properties.sv ====
/* endpoint stream properties */
`timescale 1ns/1ns

module pcie_mmio_properties (
  input logic                      user_clk,
  input logic                      core_reset,
  input pcie_mmio_pkg::axis_beat_t tx_beat,
  input logic                      tx_valid,
  input logic                      tx_ready,
  input logic                      rd_strobe,
  input logic                      cpl_done,
  input logic                      rx_ready
);

  logic rd_pending;

  // a read is owed from its strobe until the completion leaves
  always_ff @(posedge user_clk) begin
    if (core_reset) begin
      rd_pending <= 1'b0;
    end else if (rd_strobe) begin
      rd_pending <= 1'b1;
    end else if (cpl_done) begin
      rd_pending <= 1'b0;
    end
  end

  tx_hold: assert property (@(posedge user_clk) disable iff (core_reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
    else $error("tx beat changed or dropped before it was accepted");

  rx_stall: assert property (@(posedge user_clk) disable iff (core_reset)
    rd_strobe || rd_pending |-> !rx_ready)
    else $error("rx_ready high while a read completion is pending");

  // one reset edge clears the builder first
  tx_quiet: assert property (@(posedge user_clk)
    core_reset && $past(core_reset) |-> !tx_valid)
    else $error("tx_valid high during core reset");

endmodule

bind pcie_mmio_top pcie_mmio_properties i_properties (
  .user_clk   (user_clk),
  .core_reset (core_reset),
  .tx_beat    (tx_beat),
  .tx_valid   (tx_valid),
  .tx_ready   (tx_ready),
  .rd_strobe  (req.rd_en),
  .cpl_done   (cpl_done),
  .rx_ready   (rx_ready)
);

// ==== pcie_mmio_top.sv ====
/* pcie mmio endpoint */
`timescale 1ns/1ns

module pcie_mmio_top #(
  parameter int RESET_HOLD = 16
) (
  input  logic                         user_clk,
  input  logic                         NO_RESET,
  input  logic                         link_up,
  input  pcie_mmio_pkg::completer_id_t cfg_completer_id,
  input  pcie_mmio_pkg::axis_beat_t    rx_beat,
  input  logic                         rx_valid,
  input  logic                         tx_ready,
  output logic                         rx_ready,
  output pcie_mmio_pkg::axis_beat_t    tx_beat,
  output logic                         tx_valid,
  output logic [3:0]                   led
);
  import pcie_mmio_pkg::*;

  logic        core_reset;
  mmio_req_t   req;
  logic [31:0] rd_data;
  logic        cpl_start;
  cpl_info_t   cpl_info;
  logic        cpl_done;

  pcie_reset_seq #(
    .RESET_HOLD (RESET_HOLD)
  ) i_reset_seq (
    .user_clk   (user_clk),
    .NO_RESET   (NO_RESET),
    .link_up    (link_up),
    .core_reset (core_reset),
    .led        (led)
  );

  tlp_rx_decoder i_rx_decoder (
    .user_clk   (user_clk),
    .core_reset (core_reset),
    .rx_beat    (rx_beat),
    .rx_valid   (rx_valid),
    .cpl_done   (cpl_done),
    .rx_ready   (rx_ready),
    .req        (req),
    .cpl_start  (cpl_start),
    .cpl_info   (cpl_info)
  );

  mmio_regfile i_regfile (
    .user_clk   (user_clk),
    .core_reset (core_reset),
    .req        (req),
    .rd_data    (rd_data)
  );

  tlp_cpl_builder i_cpl_builder (
    .user_clk         (user_clk),
    .core_reset       (core_reset),
    .cfg_completer_id (cfg_completer_id),
    .cpl_start        (cpl_start),
    .cpl_info         (cpl_info),
    .rd_data          (rd_data),
    .tx_ready         (tx_ready),
    .tx_beat          (tx_beat),
    .tx_valid         (tx_valid),
    .cpl_done         (cpl_done)
  );

endmodule

// ==== tlp_cpl_builder.sv ====
/* completion with data builder */
`timescale 1ns/1ns

module tlp_cpl_builder (
  input  logic                         user_clk,
  input  logic                         core_reset,
  input  pcie_mmio_pkg::completer_id_t cfg_completer_id,
  input  logic                         cpl_start,
  input  pcie_mmio_pkg::cpl_info_t     cpl_info,
  input  logic [31:0]                  rd_data,
  input  logic                         tx_ready,
  output pcie_mmio_pkg::axis_beat_t    tx_beat,
  output logic                         tx_valid,
  output logic                         cpl_done
);
  import pcie_mmio_pkg::*;

  cpl_state_e  state;
  logic [31:0] data_q;
  logic [31:0] hdr_dw0;
  logic [31:0] hdr_dw1;
  logic [31:0] hdr_dw2;
  logic        in_beat1;

  // fmt/type, zero tc and attributes, one dword
  assign hdr_dw0 = {FMT_TYPE_CPLD, 14'd0, LEN_ONE};
  // completer id, successful status, bcm clear
  assign hdr_dw1 = {cfg_completer_id, CPL_STATUS_SC, 1'b0, CPL_BYTE_COUNT};
  assign hdr_dw2 = {cpl_info.requester_id, cpl_info.tag, 1'b0, cpl_info.lower_addr};

  assign in_beat1 = (state == cpl_beat1);

  // beat 0 needs no read data, so it goes out with cpl_start
  assign tx_valid = cpl_start || (state != cpl_idle);
  assign cpl_done = in_beat1 && tx_ready;

  always_comb begin
    tx_beat.keep = '1;
    tx_beat.last = in_beat1;
    if (in_beat1) begin
      tx_beat.data = {data_q, hdr_dw2};
    end else begin
      tx_beat.data = {hdr_dw1, hdr_dw0};
    end
  end

  always_ff @(posedge user_clk) begin
    if (core_reset) begin
      state <= cpl_idle;
    end else begin
      case (state)
        cpl_idle: begin
          // beat 0 may already be taken in the start cycle
          if (cpl_start) begin
            state <= tx_ready ? cpl_beat1 : cpl_beat0;
          end
        end
        cpl_beat0: begin
          if (tx_ready) begin
            state <= cpl_beat1;
          end
        end
        cpl_beat1: begin
          if (tx_ready) begin
            state <= cpl_idle;
          end
        end
        default: state <= cpl_idle;
      endcase
    end
  end

  // hold the read word for beat 1
  always_ff @(posedge user_clk) begin
    if (cpl_start && state == cpl_idle) begin
      data_q <= rd_data;
    end
  end

endmodule

// ==== mmio_regfile.sv ====
/* mmio register file */
`timescale 1ns/1ns

module mmio_regfile (
  input  logic                     user_clk,
  input  logic                     core_reset,
  input  pcie_mmio_pkg::mmio_req_t req,
  output logic [31:0]              rd_data
);
  import pcie_mmio_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  // index 0 is the identity word and has no storage
  logic [31:0] regs [1:NUM_REGS-1];
  logic        wr_hit;

  assign wr_hit = req.wr_en && (req.idx != '0);

  always_ff @(posedge user_clk) begin
    if (core_reset) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      // only the enabled byte lanes change
      for (int b = 0; b < 4; b++) begin
        if (req.be[b]) begin
          regs[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // registered read, answers one cycle after the strobe
  always_ff @(posedge user_clk) begin
    if (req.rd_en) begin
      if (req.idx == '0) begin
        rd_data <= ID_WORD;
      end else begin
        rd_data <= regs[req.idx];
      end
    end
  end

endmodule

// ==== tlp_rx_decoder.sv ====
/* tlp receive decoder */
`timescale 1ns/1ns

module tlp_rx_decoder (
  input  logic                      user_clk,
  input  logic                      core_reset,
  input  pcie_mmio_pkg::axis_beat_t rx_beat,
  input  logic                      rx_valid,
  input  logic                      cpl_done,
  output logic                      rx_ready,
  output pcie_mmio_pkg::mmio_req_t  req,
  output logic                      cpl_start,
  output pcie_mmio_pkg::cpl_info_t  cpl_info
);
  import pcie_mmio_pkg::*;

  rx_state_e             state;
  tlp_kind_e             hdr_kind;
  tlp_kind_e             kind;
  logic                  rx_take;
  logic [7:0]            fmt_type;
  logic [9:0]            length;
  logic [1:0]            byte_off;
  logic [3:0]            first_be;
  logic [15:0]           requester_id;
  logic [7:0]            tag;
  logic [6:0]            lower_addr;
  logic                  req_wr;
  logic                  req_rd;
  logic [REG_ADDR_W-1:0] req_idx;
  logic [31:0]           req_wdata;

  // stall the stream while a read completion is owed
  assign rx_ready = (state != rx_wait_cpl);
  assign rx_take  = rx_valid && rx_ready;

  // header dword 0 sits in the low half of beat 0
  assign fmt_type = rx_beat.data[31:24];
  assign length   = rx_beat.data[9:0];

  always_comb begin
    if (length != LEN_ONE) begin
      hdr_kind = kind_unsupported;
    end else if (fmt_type == FMT_TYPE_MWR32) begin
      hdr_kind = kind_mem_wr;
    end else if (fmt_type == FMT_TYPE_MRD32) begin
      hdr_kind = kind_mem_rd;
    end else begin
      hdr_kind = kind_unsupported;
    end
  end

  // offset of the first enabled byte, for the completion lower address
  always_comb begin
    casez (first_be)
      4'b???1: byte_off = 2'd0;
      4'b??10: byte_off = 2'd1;
      4'b?100: byte_off = 2'd2;
      4'b1000: byte_off = 2'd3;
      default: byte_off = 2'd0;
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (core_reset) begin
      state     <= rx_hdr;
      req_wr    <= 1'b0;
      req_rd    <= 1'b0;
      cpl_start <= 1'b0;
    end else begin
      req_wr    <= 1'b0;
      req_rd    <= 1'b0;
      // read data is out of the register file one cycle after the strobe
      cpl_start <= req_rd;
      case (state)
        rx_hdr: begin
          // single-beat packets are never ours and fall through here
          if (rx_take && !rx_beat.last) begin
            state <= (hdr_kind == kind_unsupported) ? rx_drop : rx_addr;
          end
        end
        rx_addr: begin
          if (rx_take) begin
            if (!rx_beat.last) begin
              state <= rx_drop;
            end else if (kind == kind_mem_rd) begin
              req_rd <= 1'b1;
              state  <= rx_wait_cpl;
            end else begin
              req_wr <= 1'b1;
              state  <= rx_hdr;
            end
          end
        end
        rx_drop: begin
          if (rx_take && rx_beat.last) begin
            state <= rx_hdr;
          end
        end
        rx_wait_cpl: begin
          if (cpl_done) begin
            state <= rx_hdr;
          end
        end
        default: state <= rx_hdr;
      endcase
    end
  end

  // header dword 1 in the high half of beat 0, address and data in beat 1
  always_ff @(posedge user_clk) begin
    if (rx_take && state == rx_hdr) begin
      kind         <= hdr_kind;
      requester_id <= rx_beat.data[63:48];
      tag          <= rx_beat.data[47:40];
      first_be     <= rx_beat.data[35:32];
    end
    if (rx_take && state == rx_addr) begin
      req_idx    <= rx_beat.data[REG_ADDR_W+1:2];
      req_wdata  <= rx_beat.data[63:32];
      lower_addr <= {rx_beat.data[6:2], byte_off};
    end
  end

  assign req = '{
    wr_en: req_wr,
    rd_en: req_rd,
    idx:   req_idx,
    wdata: req_wdata,
    be:    first_be
  };

  assign cpl_info = '{
    requester_id: requester_id,
    tag:          tag,
    lower_addr:   lower_addr
  };

endmodule

// ==== pcie_reset_seq.sv ====
/* power-up reset hold */
`timescale 1ns/1ns

module pcie_reset_seq #(
  parameter int RESET_HOLD = 4096
) (
  input  logic       user_clk,
  input  logic       NO_RESET,
  input  logic       link_up,
  output logic       core_reset,
  output logic [3:0] led
);

  localparam int CNT_W = $clog2(RESET_HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;
  logic             link_up_q;

  // counter saturates at RESET_HOLD, core stays in reset until then
  always_ff @(posedge user_clk) begin
    if (NO_RESET) begin
      hold_cnt   <= '0;
      core_reset <= 1'b1;
    end else if (hold_cnt != CNT_W'(RESET_HOLD)) begin
      hold_cnt   <= hold_cnt + 1'b1;
      core_reset <= 1'b1;
    end else begin
      core_reset <= 1'b0;
    end
  end

  always_ff @(posedge user_clk) begin
    link_up_q <= link_up;
  end

  // lights are active low, upper two stay dark
  assign led = ~{2'b00, core_reset, link_up_q};

endmodule

// ==== pcie_mmio_pkg.sv ====
/* pcie mmio endpoint types */

package pcie_mmio_pkg;

  // stream geometry
  localparam int DATA_W      = 64;
  localparam int DW_PER_BEAT = 2;

  // 16 registers of 32 bits, indexed by address bits 5..2
  localparam int REG_ADDR_W = 4;

  localparam logic [31:0] ID_WORD = 32'h9999_10ee;

  // header format/type codes
  localparam logic [7:0] FMT_TYPE_MRD32 = 8'h00;
  localparam logic [7:0] FMT_TYPE_MWR32 = 8'h40;
  localparam logic [7:0] FMT_TYPE_CPLD  = 8'h4a;

  // header fields for single dword transfers
  localparam logic [9:0]  LEN_ONE        = 10'd1;
  localparam logic [2:0]  CPL_STATUS_SC  = 3'b000;
  localparam logic [11:0] CPL_BYTE_COUNT = 12'd4;

  // one beat of the rx or tx stream, valid and ready travel beside it
  typedef struct packed {
    logic [DATA_W-1:0]      data;
    logic [DW_PER_BEAT-1:0] keep;
    logic                   last;
  } axis_beat_t;

  typedef struct packed {
    logic [7:0] bus;
    logic [4:0] dev;
    logic [2:0] func;
  } completer_id_t;

  // register bus request, strobes last one cycle
  typedef struct packed {
    logic                  wr_en;
    logic                  rd_en;
    logic [REG_ADDR_W-1:0] idx;
    logic [31:0]           wdata;
    logic [3:0]            be;
  } mmio_req_t;

  // what the completion needs to echo back
  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [6:0]  lower_addr;
  } cpl_info_t;

  typedef enum logic [1:0] {
    kind_mem_rd,
    kind_mem_wr,
    kind_unsupported
  } tlp_kind_e;

  typedef enum logic [1:0] {
    rx_hdr,
    rx_addr,
    rx_drop,
    rx_wait_cpl
  } rx_state_e;

  typedef enum logic [1:0] {
    cpl_idle,
    cpl_beat0,
    cpl_beat1
  } cpl_state_e;

endpackage
